// ==== Bender.yml ====
package:
  name: npu_top

sources:
  - npu_cfg_pkg.sv
  - npu_op_pkg.sv
  - sram_bank_array.sv
  - sram_arbiter.sv
  - stream_loader.sv
  - elementwise_engine.sv
  - stream_unloader.sv
  - npu_top.sv
  - target: test
    files:
      - npu_tb.sv

// ==== elementwise_engine.sv ====
`timescale 1ns/1ps

module elementwise_engine (
    input  logic                            s00_axis_aclk,
    input  logic                            reset_i,
    input  logic                            start_i,
    input  npu_op_pkg::elem_op_e            op_i,
    input  logic [npu_cfg_pkg::count_w-1:0] word_count_i,
    output logic                            req_o,
    output logic                            we_o,
    output logic [npu_cfg_pkg::addr_w-1:0]  addr_o,
    output logic [npu_cfg_pkg::word_w-1:0]  wdata_o,
    input  logic                            gnt_i,
    input  logic [npu_cfg_pkg::word_w-1:0]  rdata_i,
    output logic                            done_o
);
    import npu_cfg_pkg::*;
    import npu_op_pkg::*;

    // int8 clamp bounds
    localparam int sat_max = 2 ** (lane_w - 1) - 1;
    localparam int sat_min = -(2 ** (lane_w - 1));

    typedef enum logic [2:0] {
        E_IDLE,
        E_RD_A,
        E_RD_B,
        E_CAP_B,
        E_WR_R
    } eng_state_e;

    eng_state_e            state_q;
    logic [offset_w-1:0]   offset_q;
    logic                  a_pend_q;
    logic [word_w-1:0]     a_q;
    logic [word_w-1:0]     b_q;
    logic [bank_sel_w-1:0] bank;
    logic                  last_word;

    assign last_word = (count_w'(offset_q) + count_w'(1)) == word_count_i;

    always_comb begin
        case (state_q)
            E_RD_A:  bank = bank_sel_w'(bank_a);
            E_RD_B:  bank = bank_sel_w'(bank_b);
            default: bank = bank_sel_w'(bank_r);
        endcase
    end

    assign req_o  = (state_q == E_RD_A) || (state_q == E_RD_B) || (state_q == E_WR_R);
    assign we_o   = state_q == E_WR_R;
    assign addr_o = {bank, offset_q};

    // ----------------------------------------
    // per-word sequence
    // ----------------------------------------
    always_ff @(posedge s00_axis_aclk) begin
        if (reset_i) begin
            state_q  <= E_IDLE;
            offset_q <= '0;
            a_pend_q <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            a_pend_q <= (state_q == E_RD_A) && gnt_i;
            done_o   <= 1'b0;
            case (state_q)
                E_IDLE: begin
                    if (start_i) begin
                        offset_q <= '0;
                        state_q  <= E_RD_A;
                    end
                end
                E_RD_A: begin
                    if (gnt_i) begin
                        state_q <= E_RD_B;
                    end
                end
                E_RD_B: begin
                    if (gnt_i) begin
                        state_q <= E_CAP_B;
                    end
                end
                E_CAP_B: state_q <= E_WR_R;
                E_WR_R: begin
                    if (gnt_i && last_word) begin
                        state_q <= E_IDLE;
                        done_o  <= 1'b1;
                    end else if (gnt_i) begin
                        offset_q <= offset_q + 1'b1;
                        state_q  <= E_RD_A;
                    end
                end
                default: state_q <= E_IDLE;
            endcase
        end
    end

    // operands land one cycle after their read grant
    always_ff @(posedge s00_axis_aclk) begin
        if (a_pend_q) begin
            a_q <= rdata_i;
        end
        if (state_q == E_CAP_B) begin
            b_q <= rdata_i;
        end
    end

    // ----------------------------------------
    // lane arithmetic with saturation
    // ----------------------------------------
    always_comb begin
        logic signed [lane_w-1:0] la;
        logic signed [lane_w-1:0] lb;
        logic signed [2*lane_w:0] full;
        wdata_o = '0;
        for (int i = 0; i < num_lanes; i++) begin
            la = a_q[i*lane_w +: lane_w];
            lb = b_q[i*lane_w +: lane_w];
            case (op_i)
                OP_ADD:  full = la + lb;
                OP_SUB:  full = la - lb;
                OP_MUL:  full = la * lb;
                default: full = '0;
            endcase
            if (full > sat_max) begin
                wdata_o[i*lane_w +: lane_w] = lane_w'(sat_max);
            end else if (full < sat_min) begin
                wdata_o[i*lane_w +: lane_w] = lane_w'(sat_min);
            end else begin
                wdata_o[i*lane_w +: lane_w] = full[lane_w-1:0];
            end
        end
    end

endmodule

// ==== npu_cfg_pkg.sv ====
package npu_cfg_pkg;

    // word and lane geometry
    localparam int unsigned word_w    = 64;
    localparam int unsigned lane_w    = 8;
    localparam int unsigned num_lanes = word_w / lane_w;

    // ----------------------------------------
    // sram organisation
    // ----------------------------------------
    localparam int unsigned bank_depth = 64;
    localparam int unsigned bank_sel_w = 2;
    localparam int unsigned offset_w   = $clog2(bank_depth);
    localparam int unsigned addr_w     = bank_sel_w + offset_w;

    // counts run from 0 up to bank_depth inclusive
    localparam int unsigned count_w = $clog2(bank_depth + 1);

    // bank numbers, upper address bits
    localparam int unsigned bank_a = 0;
    localparam int unsigned bank_b = 1;
    localparam int unsigned bank_r = 2;

endpackage

// ==== npu_op_pkg.sv ====
package npu_op_pkg;

    // layer controller states
    typedef enum logic [1:0] {
        IDLE,
        WAIT_OP,
        OP_DONE,
        WRITE_OUTPUT
    } npu_state_e;

    // element-wise opcode, the fourth encoding is unused
    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL
    } elem_op_e;

    // sram requesters, listed from highest to lowest priority
    typedef enum logic [1:0] {
        REQ_ENGINE,
        REQ_LOADER,
        REQ_UNLOADER
    } requester_e;

endpackage

// ==== npu_tb.sv ====
`timescale 1ns/1ps

module npu_tb;
    import npu_cfg_pkg::*;
    import npu_op_pkg::*;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 8;
    // each test word is loaded, computed and unloaded
    localparam int total_words    = 4 * (16 + 2 * 12 + 20 + 8 + 24 + 6);
    localparam int cycles_per_word = 40;
    localparam int timeout_ns = (reset_cycles + total_words * cycles_per_word) * clk_period;

    logic               s00_axis_aclk = 1'b0;
    logic               reset_i;
    logic               s00_axis_tvalid;
    logic [word_w-1:0]  s00_axis_tdata;
    logic               s00_axis_tlast;
    logic               s00_axis_tuser;
    logic               s00_axis_tready;
    logic               m00_axis_tvalid;
    logic [word_w-1:0]  m00_axis_tdata;
    logic               m00_axis_tlast;
    logic               m00_axis_tready;
    logic               op_start;
    elem_op_e           op_sel;
    logic [count_w-1:0] word_count;
    logic               finish_calc;
    logic               layer_calc_done;

    // reference banks and loader offset
    logic [word_w-1:0]   model_a [bank_depth];
    logic [word_w-1:0]   model_b [bank_depth];
    logic [word_w-1:0]   model_r [bank_depth];
    int                  ld_offset = 0;
    logic [31:0]         rng_state = 32'h43e9;
    string               test_name = "reset";
    int                  ops_run = 0;
    int                  done_seen = 0;

    npu_top UUT (
        .s00_axis_aclk     (s00_axis_aclk),
        .reset_i           (reset_i),
        .s00_axis_tvalid_i (s00_axis_tvalid),
        .s00_axis_tdata_i  (s00_axis_tdata),
        .s00_axis_tlast_i  (s00_axis_tlast),
        .s00_axis_tuser_i  (s00_axis_tuser),
        .s00_axis_tready_o (s00_axis_tready),
        .m00_axis_tvalid_o (m00_axis_tvalid),
        .m00_axis_tdata_o  (m00_axis_tdata),
        .m00_axis_tlast_o  (m00_axis_tlast),
        .m00_axis_tready_i (m00_axis_tready),
        .op_start_i        (op_start),
        .op_i              (op_sel),
        .word_count_i      (word_count),
        .finish_calc_i     (finish_calc),
        .layer_calc_done_o (layer_calc_done)
    );

    always #(clk_period / 2) s00_axis_aclk = ~s00_axis_aclk;

    always @(negedge s00_axis_aclk) begin
        if (layer_calc_done) begin
            done_seen++;
        end
    end

    // ----------------------------------------
    // random numbers and reference model
    // ----------------------------------------
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic elem_op_e pick_op();
        case (next_rand() % 3)
            0: return OP_ADD;
            1: return OP_SUB;
            default: return OP_MUL;
        endcase
    endfunction

    // half the lanes near the int8 limits when extreme is set
    function automatic logic [word_w-1:0] make_word(input bit extreme);
        logic [word_w-1:0] w;
        logic [31:0]       r;
        for (int i = 0; i < num_lanes; i++) begin
            r = next_rand();
            if (extreme && r[27]) begin
                case (r[30:28])
                    0: w[i*lane_w +: lane_w] = 8'h80;
                    1: w[i*lane_w +: lane_w] = 8'h81;
                    2: w[i*lane_w +: lane_w] = 8'h7f;
                    3: w[i*lane_w +: lane_w] = 8'h7e;
                    4: w[i*lane_w +: lane_w] = 8'hff;
                    5: w[i*lane_w +: lane_w] = 8'h01;
                    6: w[i*lane_w +: lane_w] = 8'hc0;
                    default: w[i*lane_w +: lane_w] = 8'h40;
                endcase
            end else begin
                w[i*lane_w +: lane_w] = r[23:16];
            end
        end
        return w;
    endfunction

    function automatic logic [word_w-1:0] model_word(input elem_op_e op,
                                                     input logic [word_w-1:0] a,
                                                     input logic [word_w-1:0] b);
        logic [word_w-1:0] w;
        int                x;
        int                y;
        int                v;
        for (int i = 0; i < num_lanes; i++) begin
            x = $signed(a[i*lane_w +: lane_w]);
            y = $signed(b[i*lane_w +: lane_w]);
            case (op)
                OP_ADD:  v = x + y;
                OP_SUB:  v = x - y;
                default: v = x * y;
            endcase
            if (v > 127) begin
                v = 127;
            end else if (v < -128) begin
                v = -128;
            end
            w[i*lane_w +: lane_w] = v[7:0];
        end
        return w;
    endfunction

    task automatic check_value(input string what, input logic [word_w-1:0] expected,
                               input logic [word_w-1:0] actual);
        if (actual !== expected) begin
            $display("Error: [%s] %s expected %h, actual %h", test_name, what, expected, actual);
            $display("Some tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // ----------------------------------------
    // stream and control drivers
    // ----------------------------------------
    task automatic load_block(input logic user, input int n, input bit tlast_at_end,
                              input bit extreme);
        int          i;
        logic        held;
        logic [31:0] r;
        i = 0;
        held = 1'b0;
        while (i < n) begin
            @(posedge s00_axis_aclk);
            if (!held) begin
                r = next_rand();
                if (r[30:28] == 3'd0) begin
                    s00_axis_tvalid <= 1'b0;
                end else begin
                    s00_axis_tvalid <= 1'b1;
                    s00_axis_tdata  <= make_word(extreme);
                    s00_axis_tlast  <= tlast_at_end && (i == n - 1);
                    s00_axis_tuser  <= user;
                end
            end
            @(negedge s00_axis_aclk);
            held = s00_axis_tvalid && !s00_axis_tready;
            if (s00_axis_tvalid && s00_axis_tready) begin
                if (user) begin
                    model_b[ld_offset] = s00_axis_tdata;
                end else begin
                    model_a[ld_offset] = s00_axis_tdata;
                end
                ld_offset = s00_axis_tlast ? 0 : ld_offset + 1;
                i++;
            end
        end
        @(posedge s00_axis_aclk);
        s00_axis_tvalid <= 1'b0;
        s00_axis_tlast  <= 1'b0;
    endtask

    task automatic run_op(input elem_op_e op, input int n);
        @(posedge s00_axis_aclk);
        op_sel     <= op;
        word_count <= count_w'(n);
        op_start   <= 1'b1;
        @(posedge s00_axis_aclk);
        op_start <= 1'b0;
        ops_run++;
        for (int i = 0; i < n; i++) begin
            model_r[i] = model_word(op, model_a[i], model_b[i]);
        end
        @(negedge s00_axis_aclk);
        while (!layer_calc_done) begin
            check_value("input tready during op", 0, s00_axis_tready);
            @(negedge s00_axis_aclk);
        end
        @(negedge s00_axis_aclk);
        check_value("done pulse width", 0, layer_calc_done);
    endtask

    task automatic unload_block(input int n, input int ready_pct);
        int                i;
        logic [31:0]       r;
        logic              stalled;
        logic [word_w-1:0] held_data;
        @(posedge s00_axis_aclk);
        word_count  <= count_w'(n);
        finish_calc <= 1'b1;
        @(posedge s00_axis_aclk);
        finish_calc <= 1'b0;
        i = 0;
        stalled = 1'b0;
        while (i < n) begin
            @(posedge s00_axis_aclk);
            r = next_rand();
            m00_axis_tready <= ((r >> 8) % 100) < ready_pct;
            @(negedge s00_axis_aclk);
            if (stalled) begin
                check_value("valid held under stall", 1, m00_axis_tvalid);
                check_value("data held under stall", held_data, m00_axis_tdata);
            end
            if (m00_axis_tvalid && m00_axis_tready) begin
                check_value($sformatf("output word %0d", i), model_r[i], m00_axis_tdata);
                check_value($sformatf("tlast on word %0d", i), i == n - 1, m00_axis_tlast);
                stalled = 1'b0;
                i++;
            end else begin
                stalled = m00_axis_tvalid;
                held_data = m00_axis_tdata;
            end
        end
        @(posedge s00_axis_aclk);
        m00_axis_tready <= 1'b0;
        @(negedge s00_axis_aclk);
        check_value("output valid after tlast", 0, m00_axis_tvalid);
    endtask

    // watchdog
    initial begin
        #(timeout_ns);
        $display("Timeout: the DUT stopped responding before all tests finished");
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        reset_i = 1'b1;
        s00_axis_tvalid = 1'b0;
        s00_axis_tdata = '0;
        s00_axis_tlast = 1'b0;
        s00_axis_tuser = 1'b0;
        m00_axis_tready = 1'b0;
        op_start = 1'b0;
        op_sel = OP_ADD;
        word_count = '0;
        finish_calc = 1'b0;
        repeat (reset_cycles) @(posedge s00_axis_aclk);
        reset_i <= 1'b0;
        @(negedge s00_axis_aclk);
        check_value("input tready after reset", 0, s00_axis_tready);
        check_value("output valid after reset", 0, m00_axis_tvalid);
        check_value("output tlast after reset", 0, m00_axis_tlast);
        check_value("done after reset", 0, layer_calc_done);

        test_name = "load and add";
        load_block(1'b0, 16, 1'b1, 1'b0);
        load_block(1'b1, 16, 1'b1, 1'b0);
        run_op(OP_ADD, 16);
        unload_block(16, 60);

        test_name = "sub and mul saturation";
        load_block(1'b0, 12, 1'b1, 1'b1);
        load_block(1'b1, 12, 1'b1, 1'b1);
        run_op(OP_SUB, 12);
        unload_block(12, 60);
        run_op(OP_MUL, 12);
        unload_block(12, 60);

        test_name = "output back-pressure";
        load_block(1'b0, 20, 1'b1, 1'b0);
        load_block(1'b1, 20, 1'b1, 1'b0);
        run_op(pick_op(), 20);
        unload_block(20, 25);

        // words offered during an op wait for IDLE and continue the offsets
        test_name = "input stall during op";
        load_block(1'b0, 10, 1'b0, 1'b0);
        fork
            run_op(pick_op(), 8);
            begin
                repeat (2) @(posedge s00_axis_aclk);
                load_block(1'b0, 14, 1'b1, 1'b0);
            end
        join
        load_block(1'b1, 24, 1'b1, 1'b1);
        run_op(pick_op(), 24);
        unload_block(24, 50);

        test_name = "reload after tlast";
        load_block(1'b0, 6, 1'b1, 1'b0);
        load_block(1'b1, 6, 1'b1, 1'b1);
        run_op(pick_op(), 6);
        unload_block(6, 60);

        test_name = "done pulse count";
        check_value("done pulses", ops_run, done_seen);

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== npu_top.f ====
npu_cfg_pkg.sv
npu_op_pkg.sv
sram_bank_array.sv
sram_arbiter.sv
stream_loader.sv
elementwise_engine.sv
stream_unloader.sv
npu_top.sv
npu_tb.sv

// ==== npu_top.sv ====
`timescale 1ns/1ps

module npu_top (
    input  logic                            s00_axis_aclk,
    input  logic                            reset_i,
    // input stream
    input  logic                            s00_axis_tvalid_i,
    input  logic [npu_cfg_pkg::word_w-1:0]  s00_axis_tdata_i,
    input  logic                            s00_axis_tlast_i,
    input  logic                            s00_axis_tuser_i,
    output logic                            s00_axis_tready_o,
    // output stream
    output logic                            m00_axis_tvalid_o,
    output logic [npu_cfg_pkg::word_w-1:0]  m00_axis_tdata_o,
    output logic                            m00_axis_tlast_o,
    input  logic                            m00_axis_tready_i,
    // layer control
    input  logic                            op_start_i,
    input  npu_op_pkg::elem_op_e            op_i,
    input  logic [npu_cfg_pkg::count_w-1:0] word_count_i,
    input  logic                            finish_calc_i,
    output logic                            layer_calc_done_o
);
    import npu_cfg_pkg::*;
    import npu_op_pkg::*;

    npu_state_e        state_q;
    npu_state_e        state_d;

    logic              load_en;
    logic              eng_start;
    logic              ul_start;

    logic              eng_req;
    logic              eng_we;
    logic [addr_w-1:0] eng_addr;
    logic [word_w-1:0] eng_wdata;
    logic              eng_gnt;
    logic              eng_done;

    logic              ld_req;
    logic [addr_w-1:0] ld_addr;
    logic [word_w-1:0] ld_wdata;
    logic              ld_gnt;

    logic              ul_req;
    logic [addr_w-1:0] ul_addr;
    logic              ul_gnt;
    logic              ul_done;

    logic [word_w-1:0] sram_rdata;

    // ----------------------------------------
    // layer state machine
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // op_start wins over finish_calc
                if (op_start_i) begin
                    state_d = WAIT_OP;
                end else if (finish_calc_i) begin
                    state_d = WRITE_OUTPUT;
                end
            end
            WAIT_OP: begin
                if (eng_done) begin
                    state_d = OP_DONE;
                end
            end
            OP_DONE: state_d = IDLE;
            WRITE_OUTPUT: begin
                if (ul_done) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge s00_axis_aclk) begin
        if (reset_i) begin
            state_q           <= IDLE;
            layer_calc_done_o <= 1'b0;
        end else begin
            state_q           <= state_d;
            layer_calc_done_o <= state_q == OP_DONE;
        end
    end

    assign load_en   = state_q == IDLE;
    assign eng_start = (state_q == IDLE) && op_start_i;
    assign ul_start  = (state_q == IDLE) && !op_start_i && finish_calc_i;

    // ----------------------------------------
    // peers around the shared sram
    // ----------------------------------------
    stream_loader u_loader (
        .s00_axis_aclk (s00_axis_aclk),
        .reset_i       (reset_i),
        .load_en_i     (load_en),
        .tvalid_i      (s00_axis_tvalid_i),
        .tdata_i       (s00_axis_tdata_i),
        .tlast_i       (s00_axis_tlast_i),
        .tuser_i       (s00_axis_tuser_i),
        .tready_o      (s00_axis_tready_o),
        .req_o         (ld_req),
        .addr_o        (ld_addr),
        .wdata_o       (ld_wdata),
        .gnt_i         (ld_gnt)
    );

    elementwise_engine u_engine (
        .s00_axis_aclk (s00_axis_aclk),
        .reset_i       (reset_i),
        .start_i       (eng_start),
        .op_i          (op_i),
        .word_count_i  (word_count_i),
        .req_o         (eng_req),
        .we_o          (eng_we),
        .addr_o        (eng_addr),
        .wdata_o       (eng_wdata),
        .gnt_i         (eng_gnt),
        .rdata_i       (sram_rdata),
        .done_o        (eng_done)
    );

    stream_unloader u_unloader (
        .s00_axis_aclk (s00_axis_aclk),
        .reset_i       (reset_i),
        .start_i       (ul_start),
        .word_count_i  (word_count_i),
        .req_o         (ul_req),
        .addr_o        (ul_addr),
        .gnt_i         (ul_gnt),
        .rdata_i       (sram_rdata),
        .tvalid_o      (m00_axis_tvalid_o),
        .tdata_o       (m00_axis_tdata_o),
        .tlast_o       (m00_axis_tlast_o),
        .tready_i      (m00_axis_tready_i),
        .done_o        (ul_done)
    );

    // loader only writes, unloader only reads
    sram_arbiter u_arbiter (
        .s00_axis_aclk (s00_axis_aclk),
        .reset_i       (reset_i),
        .eng_req_i     (eng_req),
        .eng_we_i      (eng_we),
        .eng_addr_i    (eng_addr),
        .eng_wdata_i   (eng_wdata),
        .eng_gnt_o     (eng_gnt),
        .ld_req_i      (ld_req),
        .ld_we_i       (1'b1),
        .ld_addr_i     (ld_addr),
        .ld_wdata_i    (ld_wdata),
        .ld_gnt_o      (ld_gnt),
        .ul_req_i      (ul_req),
        .ul_we_i       (1'b0),
        .ul_addr_i     (ul_addr),
        .ul_wdata_i    ('0),
        .ul_gnt_o      (ul_gnt),
        .rdata_o       (sram_rdata)
    );

endmodule

// ==== sram_arbiter.sv ====
`timescale 1ns/1ps

module sram_arbiter (
    input  logic                            s00_axis_aclk,
    input  logic                            reset_i,
    // engine
    input  logic                            eng_req_i,
    input  logic                            eng_we_i,
    input  logic [npu_cfg_pkg::addr_w-1:0]  eng_addr_i,
    input  logic [npu_cfg_pkg::word_w-1:0]  eng_wdata_i,
    output logic                            eng_gnt_o,
    // loader
    input  logic                            ld_req_i,
    input  logic                            ld_we_i,
    input  logic [npu_cfg_pkg::addr_w-1:0]  ld_addr_i,
    input  logic [npu_cfg_pkg::word_w-1:0]  ld_wdata_i,
    output logic                            ld_gnt_o,
    // unloader
    input  logic                            ul_req_i,
    input  logic                            ul_we_i,
    input  logic [npu_cfg_pkg::addr_w-1:0]  ul_addr_i,
    input  logic [npu_cfg_pkg::word_w-1:0]  ul_wdata_i,
    output logic                            ul_gnt_o,
    // shared read return
    output logic [npu_cfg_pkg::word_w-1:0]  rdata_o
);
    import npu_cfg_pkg::*;
    import npu_op_pkg::*;

    requester_e        winner;
    logic              any_req;
    logic              mem_we;
    logic [addr_w-1:0] mem_addr;
    logic [word_w-1:0] mem_wdata;
    logic [word_w-1:0] mem_rdata;
    logic              rd_valid_q;

    assign any_req = eng_req_i || ld_req_i || ul_req_i;

    // fixed priority in requester_e order
    always_comb begin
        if (eng_req_i) begin
            winner = REQ_ENGINE;
        end else if (ld_req_i) begin
            winner = REQ_LOADER;
        end else begin
            winner = REQ_UNLOADER;
        end
    end

    assign eng_gnt_o = eng_req_i && (winner == REQ_ENGINE);
    assign ld_gnt_o  = ld_req_i && (winner == REQ_LOADER);
    assign ul_gnt_o  = ul_req_i && (winner == REQ_UNLOADER);

    // ----------------------------------------
    // port mux
    // ----------------------------------------
    always_comb begin
        case (winner)
            REQ_ENGINE: begin
                mem_we    = eng_we_i;
                mem_addr  = eng_addr_i;
                mem_wdata = eng_wdata_i;
            end
            REQ_LOADER: begin
                mem_we    = ld_we_i;
                mem_addr  = ld_addr_i;
                mem_wdata = ld_wdata_i;
            end
            default: begin
                mem_we    = ul_we_i;
                mem_addr  = ul_addr_i;
                mem_wdata = ul_wdata_i;
            end
        endcase
    end

    sram_bank_array u_sram (
        .s00_axis_aclk (s00_axis_aclk),
        .en_i          (any_req),
        .we_i          (mem_we),
        .addr_i        (mem_addr),
        .wdata_i       (mem_wdata),
        .rdata_o       (mem_rdata)
    );

    // read data shows up one cycle after a read grant
    always_ff @(posedge s00_axis_aclk) begin
        if (reset_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= any_req && !mem_we;
        end
    end

    assign rdata_o = rd_valid_q ? mem_rdata : '0;

endmodule

// ==== sram_bank_array.sv ====
`timescale 1ns/1ps

module sram_bank_array (
    input  logic                            s00_axis_aclk,
    input  logic                            en_i,
    input  logic                            we_i,
    input  logic [npu_cfg_pkg::addr_w-1:0]  addr_i,
    input  logic [npu_cfg_pkg::word_w-1:0]  wdata_i,
    output logic [npu_cfg_pkg::word_w-1:0]  rdata_o
);
    import npu_cfg_pkg::*;

    localparam int unsigned num_words = (bank_r + 1) * bank_depth;

    // banks A, B and R laid out back to back
    logic [word_w-1:0] mem [0:num_words-1];

    // single port, read data registered
    always_ff @(posedge s00_axis_aclk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

// ==== stream_loader.sv ====
`timescale 1ns/1ps

module stream_loader (
    input  logic                            s00_axis_aclk,
    input  logic                            reset_i,
    input  logic                            load_en_i,
    input  logic                            tvalid_i,
    input  logic [npu_cfg_pkg::word_w-1:0]  tdata_i,
    input  logic                            tlast_i,
    input  logic                            tuser_i,
    output logic                            tready_o,
    output logic                            req_o,
    output logic [npu_cfg_pkg::addr_w-1:0]  addr_o,
    output logic [npu_cfg_pkg::word_w-1:0]  wdata_o,
    input  logic                            gnt_i
);
    import npu_cfg_pkg::*;

    logic [offset_w-1:0]   offset_q;
    logic [bank_sel_w-1:0] bank;

    // tuser picks the operand bank
    assign bank = tuser_i ? bank_sel_w'(bank_b) : bank_sel_w'(bank_a);

    assign req_o    = load_en_i && tvalid_i;
    assign tready_o = gnt_i;
    assign addr_o   = {bank, offset_q};
    assign wdata_o  = tdata_i;

    // write offset, back to zero after tlast
    always_ff @(posedge s00_axis_aclk) begin
        if (reset_i) begin
            offset_q <= '0;
        end else if (gnt_i) begin
            if (tlast_i) begin
                offset_q <= '0;
            end else begin
                offset_q <= offset_q + 1'b1;
            end
        end
    end

endmodule

// ==== stream_unloader.sv ====
`timescale 1ns/1ps

module stream_unloader (
    input  logic                            s00_axis_aclk,
    input  logic                            reset_i,
    input  logic                            start_i,
    input  logic [npu_cfg_pkg::count_w-1:0] word_count_i,
    output logic                            req_o,
    output logic [npu_cfg_pkg::addr_w-1:0]  addr_o,
    input  logic                            gnt_i,
    input  logic [npu_cfg_pkg::word_w-1:0]  rdata_i,
    output logic                            tvalid_o,
    output logic [npu_cfg_pkg::word_w-1:0]  tdata_o,
    output logic                            tlast_o,
    input  logic                            tready_i,
    output logic                            done_o
);
    import npu_cfg_pkg::*;

    typedef enum logic [1:0] {
        U_IDLE,
        U_REQ,
        U_WAIT,
        U_SEND
    } unl_state_e;

    unl_state_e          state_q;
    logic [offset_w-1:0] offset_q;

    assign req_o    = state_q == U_REQ;
    assign addr_o   = {bank_sel_w'(bank_r), offset_q};
    assign tvalid_o = state_q == U_SEND;
    assign tlast_o  = tvalid_o && ((count_w'(offset_q) + count_w'(1)) == word_count_i);
    assign done_o   = tvalid_o && tready_i && tlast_o;

    // fetch one word, then hold it until taken
    always_ff @(posedge s00_axis_aclk) begin
        if (reset_i) begin
            state_q  <= U_IDLE;
            offset_q <= '0;
        end else begin
            case (state_q)
                U_IDLE: begin
                    if (start_i) begin
                        offset_q <= '0;
                        state_q  <= U_REQ;
                    end
                end
                U_REQ: begin
                    if (gnt_i) begin
                        state_q <= U_WAIT;
                    end
                end
                U_WAIT: state_q <= U_SEND;
                U_SEND: begin
                    if (tready_i && tlast_o) begin
                        state_q <= U_IDLE;
                    end else if (tready_i) begin
                        offset_q <= offset_q + 1'b1;
                        state_q  <= U_REQ;
                    end
                end
                default: state_q <= U_IDLE;
            endcase
        end
    end

    // output register, loaded as the read returns
    always_ff @(posedge s00_axis_aclk) begin
        if (state_q == U_WAIT) begin
            tdata_o <= rdata_i;
        end
    end

endmodule
